/* alu_issue.f */
+incdir+src
src/core_types_pkg.sv
src/alu_issue_pkg.sv
src/wake_bus_if.sv
src/iq_entry.sv
src/operand_capture.sv
src/alu_unit.sv
src/alu_iq.sv
src/alu_issue_top.sv
verification/alu_issue_tb.sv

/* src/alu_iq.sv */
`timescale 1ns/1ps
`include "alu_issue_defs.svh"

module alu_iq
    import core_types_pkg::*;
    import alu_issue_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    input  logic [`ISSUE_DISPATCH_CNT-1:0]          dispatch_choose_i,
    input  decode_info_t [`ISSUE_DISPATCH_CNT-1:0]  dispatch_info_i,
    input  word_t [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0]   dispatch_data_i,
    input  rob_id_t [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0] dispatch_tag_i,
    input  logic [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0]    dispatch_valid_i,
    wake_bus_if.consumer                            wake_bus,
    input  logic                                    result_ready_i,
    output logic                                    entry_ready_o,
    output logic                                    result_valid_o,
    output word_t                                   result_data_o,
    output rob_id_t                                 result_tag_o,
    output logic                                    result_wreg_o,
    output logic                                    wkup_valid_o,
    output rob_id_t                                 wkup_tag_o,
    output word_t                                   wkup_data_o
);

    localparam int IQ_SIZE = `ISSUE_IQ_SIZE;
    localparam int AGE_W   = `ISSUE_AGING_LENGTH;
    localparam int IDX_W   = $clog2(IQ_SIZE);
    localparam int CNT_W   = $clog2(IQ_SIZE + 1);

    decode_info_t                   disp_di;
    word_t   [`ISSUE_REG_COUNT-1:0] disp_data;
    rob_id_t [`ISSUE_REG_COUNT-1:0] disp_tag;
    logic    [`ISSUE_REG_COUNT-1:0] disp_valid;
    logic                           disp_any;

    logic                 exec_free;
    logic                 issue;
    logic                 sel_valid;
    logic [IDX_W-1:0]     sel_idx;
    logic [IQ_SIZE-1:0]   entry_rdy;
    logic [IQ_SIZE-1:0]   entry_init;
    logic [IQ_SIZE-1:0]   issue_sel;
    logic [IQ_SIZE-1:0]   empty_q;
    logic                 alloc_found;
    logic [AGE_W-1:0]     aging_q [IQ_SIZE];
    logic [CNT_W-1:0]     free_q;
    logic [CNT_W-1:0]     free_d;

    decode_info_t [IQ_SIZE-1:0]                         entry_di;
    word_t [IQ_SIZE-1:0][`ISSUE_REG_COUNT-1:0]          entry_data;
    logic [IQ_SIZE-1:0][`ISSUE_REG_COUNT-1:0][`ISSUE_WKUP_COUNT-1:0] entry_hit;

    decode_info_t                   sel_di;
    decode_info_t                   ex_di_q;
    decode_info_t                   res_di_q;
    logic                           ex_valid_q;
    word_t [`ISSUE_REG_COUNT-1:0]   real_data;
    word_t                          alu_out;

    // --------------------
    // dispatch lane merge, choose is one-hot
    always_comb begin
        disp_di    = '0;
        disp_data  = '0;
        disp_tag   = '0;
        disp_valid = '0;
        for (int i = 0; i < `ISSUE_DISPATCH_CNT; i++) begin
            if (dispatch_choose_i[i]) begin
                disp_di    = dispatch_info_i[i];
                disp_data  = dispatch_data_i[i];
                disp_tag   = dispatch_tag_i[i];
                disp_valid = dispatch_valid_i[i];
            end
        end
    end

    assign disp_any  = |dispatch_choose_i;
    assign exec_free = !result_valid_o || result_ready_i;

    // --------------------
    // allocation, lowest empty slot
    always_comb begin
        entry_init  = '0;
        alloc_found = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (empty_q[i] && !alloc_found) begin
                entry_init[i] = disp_any;
                alloc_found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            empty_q <= '1;
        end else begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                if (issue_sel[i]) begin
                    empty_q[i] <= 1'b1;
                end else if (entry_init[i]) begin
                    empty_q[i] <= 1'b0;
                end
            end
        end
    end

    // free count after this cycle's dispatch and issue
    assign free_d = free_q - CNT_W'(disp_any) + CNT_W'(issue);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            free_q        <= CNT_W'(IQ_SIZE);
            entry_ready_o <= 1'b1;
        end else begin
            free_q        <= free_d;
            entry_ready_o <= (free_d != '0);
        end
    end

    // --------------------
    // aging select
    // oldest ready wins, strict compare keeps the lower index on ties
    always_comb begin
        sel_idx   = '0;
        sel_valid = 1'b0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (entry_rdy[i] && (!sel_valid || aging_q[i] > aging_q[sel_idx])) begin
                sel_idx   = IDX_W'(i);
                sel_valid = 1'b1;
            end
        end
    end

    assign issue = sel_valid & exec_free;

    always_comb begin
        issue_sel          = '0;
        issue_sel[sel_idx] = issue;
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                aging_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < IQ_SIZE; i++) begin
                if (issue_sel[i] || entry_init[i]) begin
                    aging_q[i] <= '0;
                end else if (aging_q[i] == '0) begin
                    aging_q[i] <= AGE_W'(1);
                end else if (!aging_q[i][AGE_W-1]) begin
                    // saturate at the top bit
                    aging_q[i] <= aging_q[i] << 1;
                end
            end
        end
    end

    // --------------------
    // queue slots
    for (genvar i = 0; i < IQ_SIZE; i++) begin : gen_entry
        iq_entry entry_inst (
            .clk          (clk),
            .rst_i        (rst_i),
            .flush_i      (flush_i),
            .init_i       (entry_init[i]),
            .select_i     (issue_sel[i]),
            .di_i         (disp_di),
            .data_i       (disp_data),
            .tag_i        (disp_tag),
            .data_valid_i (disp_valid),
            .wake_bus     (wake_bus),
            .ready_o      (entry_rdy[i]),
            .wkup_hit_o   (entry_hit[i]),
            .data_o       (entry_data[i]),
            .di_o         (entry_di[i])
        );
    end

    // --------------------
    // issue and execute
    assign sel_di       = entry_di[sel_idx];
    // early wakeup goes out in the issue cycle, data one cycle later
    assign wkup_valid_o = issue & sel_di.wreg;
    assign wkup_tag_o   = sel_di.wreg_id;

    operand_capture capture_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .advance_i   (exec_free),
        .data_i      (entry_data[sel_idx]),
        .wkup_hit_i  (entry_hit[sel_idx]),
        .wake_bus    (wake_bus),
        .real_data_o (real_data)
    );

    alu_unit alu_inst (
        .r0_i     (real_data[0]),
        .r1_i     (real_data[1]),
        .pc_i     (ex_di_q.pc),
        .op_i     (ex_di_q.op),
        .result_o (alu_out)
    );

    assign wkup_data_o = alu_out;

    // both stages hold while the result is stalled
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            ex_valid_q     <= 1'b0;
            result_valid_o <= 1'b0;
        end else if (exec_free) begin
            ex_valid_q     <= issue;
            result_valid_o <= ex_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_free) begin
            ex_di_q       <= sel_di;
            res_di_q      <= ex_di_q;
            result_data_o <= alu_out;
        end
    end

    assign result_tag_o  = res_di_q.wreg_id;
    assign result_wreg_o = res_di_q.wreg;

endmodule

/* src/alu_issue_defs.svh */
`ifndef ALU_ISSUE_DEFS_SVH
`define ALU_ISSUE_DEFS_SVH

// queue shape
`define ISSUE_IQ_SIZE       4
`define ISSUE_AGING_LENGTH  4

// datapath widths
`define ISSUE_WORD_WIDTH    32
`define ISSUE_ROB_ID_WIDTH  6

// lane counts
`define ISSUE_DISPATCH_CNT  2
`define ISSUE_REG_COUNT     2
`define ISSUE_CDB_COUNT     2
`define ISSUE_WKUP_COUNT    2

`endif

/* src/alu_issue_pkg.sv */
`include "alu_issue_defs.svh"

package alu_issue_pkg;

    import core_types_pkg::*;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_SLTU  = 4'd6,
        ALU_SLL   = 4'd7,
        ALU_SRL   = 4'd8,
        ALU_SRA   = 4'd9,
        // pc plus second operand
        ALU_PCADD = 4'd10
    } alu_op_e;

    // decoded instruction as seen by the issue queue
    typedef struct packed {
        logic    inst_valid;
        word_t   pc;
        alu_op_e op;
        logic    wreg;
        rob_id_t wreg_id;
    } decode_info_t;

endpackage

/* src/alu_issue_top.sv */
`timescale 1ns/1ps
`include "alu_issue_defs.svh"

module alu_issue_top
    import core_types_pkg::*;
    import alu_issue_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    input  logic [`ISSUE_DISPATCH_CNT-1:0]          dispatch_choose_i,
    input  decode_info_t [`ISSUE_DISPATCH_CNT-1:0]  dispatch_info_i,
    input  word_t [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0]   dispatch_data_i,
    input  rob_id_t [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0] dispatch_tag_i,
    input  logic [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0]    dispatch_valid_i,
    input  word_t   [`ISSUE_CDB_COUNT-1:0]          cdb_data_i,
    input  rob_id_t [`ISSUE_CDB_COUNT-1:0]          cdb_tag_i,
    input  logic    [`ISSUE_CDB_COUNT-1:0]          cdb_valid_i,
    input  word_t                                   ext_wkup_data_i,
    input  rob_id_t                                 ext_wkup_tag_i,
    input  logic                                    ext_wkup_valid_i,
    input  logic                                    result_ready_i,
    output logic                                    entry_ready_o,
    output logic                                    result_valid_o,
    output word_t                                   result_data_o,
    output rob_id_t                                 result_tag_o,
    output logic                                    result_wreg_o,
    output logic                                    wkup_valid_o,
    output rob_id_t                                 wkup_tag_o,
    output word_t                                   wkup_data_o
);

    wake_bus_if wake_bus ();

    // --------------------
    // wake bus drive
    assign wake_bus.cdb_data  = cdb_data_i;
    assign wake_bus.cdb_tag   = cdb_tag_i;
    assign wake_bus.cdb_valid = cdb_valid_i;

    // lane 0 is our own early wakeup, lane 1 comes from outside
    assign wake_bus.wkup_data  = {ext_wkup_data_i, wkup_data_o};
    assign wake_bus.wkup_tag   = {ext_wkup_tag_i, wkup_tag_o};
    assign wake_bus.wkup_valid = {ext_wkup_valid_i, wkup_valid_o};

    alu_iq alu_iq_inst (
        .clk               (clk),
        .rst_i             (rst_i),
        .flush_i           (flush_i),
        .dispatch_choose_i (dispatch_choose_i),
        .dispatch_info_i   (dispatch_info_i),
        .dispatch_data_i   (dispatch_data_i),
        .dispatch_tag_i    (dispatch_tag_i),
        .dispatch_valid_i  (dispatch_valid_i),
        .wake_bus          (wake_bus),
        .result_ready_i    (result_ready_i),
        .entry_ready_o     (entry_ready_o),
        .result_valid_o    (result_valid_o),
        .result_data_o     (result_data_o),
        .result_tag_o      (result_tag_o),
        .result_wreg_o     (result_wreg_o),
        .wkup_valid_o      (wkup_valid_o),
        .wkup_tag_o        (wkup_tag_o),
        .wkup_data_o       (wkup_data_o)
    );

endmodule

/* src/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit
    import core_types_pkg::*;
    import alu_issue_pkg::*;
(
    input  word_t   r0_i,
    input  word_t   r1_i,
    input  word_t   pc_i,
    input  alu_op_e op_i,
    output word_t   result_o
);

    // shift amount from the low five bits
    logic [4:0] shamt;

    assign shamt = r1_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:   result_o = r0_i + r1_i;
            ALU_SUB:   result_o = r0_i - r1_i;
            ALU_AND:   result_o = r0_i & r1_i;
            ALU_OR:    result_o = r0_i | r1_i;
            ALU_XOR:   result_o = r0_i ^ r1_i;
            ALU_SLT:   result_o = word_t'($signed(r0_i) < $signed(r1_i));
            ALU_SLTU:  result_o = word_t'(r0_i < r1_i);
            ALU_SLL:   result_o = r0_i << shamt;
            ALU_SRL:   result_o = r0_i >> shamt;
            ALU_SRA:   result_o = $signed(r0_i) >>> shamt;
            ALU_PCADD: result_o = pc_i + r1_i;
            default:   result_o = '0;
        endcase
    end

endmodule

/* src/core_types_pkg.sv */
`include "alu_issue_defs.svh"

package core_types_pkg;

    // one register-file word
    typedef logic [`ISSUE_WORD_WIDTH-1:0] word_t;

    // rob tag, used both as destination and as source dependency
    typedef logic [`ISSUE_ROB_ID_WIDTH-1:0] rob_id_t;

endpackage

/* src/iq_entry.sv */
`timescale 1ns/1ps
`include "alu_issue_defs.svh"

module iq_entry
    import core_types_pkg::*;
    import alu_issue_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    input  logic                                    init_i,
    input  logic                                    select_i,
    input  decode_info_t                            di_i,
    input  word_t   [`ISSUE_REG_COUNT-1:0]          data_i,
    input  rob_id_t [`ISSUE_REG_COUNT-1:0]          tag_i,
    input  logic    [`ISSUE_REG_COUNT-1:0]          data_valid_i,
    wake_bus_if.consumer                            wake_bus,
    output logic                                    ready_o,
    output logic [`ISSUE_REG_COUNT-1:0][`ISSUE_WKUP_COUNT-1:0] wkup_hit_o,
    output word_t   [`ISSUE_REG_COUNT-1:0]          data_o,
    output decode_info_t                            di_o
);

    logic                                               valid_q;
    decode_info_t                                       di_q;
    word_t   [`ISSUE_REG_COUNT-1:0]                     data_q;
    rob_id_t [`ISSUE_REG_COUNT-1:0]                     tag_q;
    logic    [`ISSUE_REG_COUNT-1:0]                     present_q;
    logic    [`ISSUE_REG_COUNT-1:0][`ISSUE_WKUP_COUNT-1:0] hit_q;

    logic                                               live;
    rob_id_t [`ISSUE_REG_COUNT-1:0]                     cur_tag;
    logic    [`ISSUE_REG_COUNT-1:0]                     cur_present;
    logic    [`ISSUE_REG_COUNT-1:0]                     next_present;
    word_t   [`ISSUE_REG_COUNT-1:0]                     next_data;
    logic    [`ISSUE_REG_COUNT-1:0][`ISSUE_WKUP_COUNT-1:0] wkup_match;

    // incoming instruction is snooped in its own dispatch cycle too
    assign live = init_i | valid_q;

    // --------------------
    // tag match
    always_comb begin
        for (int s = 0; s < `ISSUE_REG_COUNT; s++) begin
            cur_tag[s]     = init_i ? tag_i[s] : tag_q[s];
            cur_present[s] = init_i ? data_valid_i[s] : present_q[s];
            next_data[s]   = init_i ? data_i[s] : data_q[s];
            next_present[s] = cur_present[s];

            // data of a wakeup flagged last cycle
            for (int l = 0; l < `ISSUE_WKUP_COUNT; l++) begin
                if (hit_q[s][l] && !init_i) begin
                    next_data[s] = wake_bus.wkup_data[l];
                end
            end

            for (int c = 0; c < `ISSUE_CDB_COUNT; c++) begin
                if (live && !cur_present[s] && wake_bus.cdb_valid[c] &&
                    wake_bus.cdb_tag[c] == cur_tag[s]) begin
                    next_data[s]    = wake_bus.cdb_data[c];
                    next_present[s] = 1'b1;
                end
            end

            for (int l = 0; l < `ISSUE_WKUP_COUNT; l++) begin
                wkup_match[s][l] = live && !cur_present[s] && wake_bus.wkup_valid[l] &&
                                   wake_bus.wkup_tag[l] == cur_tag[s];
                if (wkup_match[s][l]) begin
                    next_present[s] = 1'b1;
                end
            end
        end
    end

    // --------------------
    // state
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q   <= 1'b0;
            present_q <= '0;
            hit_q     <= '0;
        end else begin
            if (init_i) begin
                valid_q <= 1'b1;
            end else if (select_i) begin
                valid_q <= 1'b0;
            end
            present_q <= next_present;
            hit_q     <= wkup_match;
        end
    end

    always_ff @(posedge clk) begin
        if (init_i) begin
            di_q <= di_i;
        end
        tag_q  <= cur_tag;
        data_q <= next_data;
    end

    assign ready_o    = valid_q & (&present_q);
    assign wkup_hit_o = hit_q;
    assign data_o     = data_q;
    assign di_o       = di_q;

endmodule

/* src/operand_capture.sv */
`timescale 1ns/1ps
`include "alu_issue_defs.svh"

module operand_capture
    import core_types_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_i,
    input  logic                                    flush_i,
    input  logic                                    advance_i,
    input  word_t [`ISSUE_REG_COUNT-1:0]            data_i,
    input  logic [`ISSUE_REG_COUNT-1:0][`ISSUE_WKUP_COUNT-1:0] wkup_hit_i,
    wake_bus_if.consumer                            wake_bus,
    output word_t [`ISSUE_REG_COUNT-1:0]            real_data_o
);

    word_t [`ISSUE_REG_COUNT-1:0] patched;

    // operands woken last cycle are still stale in the entry
    always_comb begin
        for (int s = 0; s < `ISSUE_REG_COUNT; s++) begin
            patched[s] = data_i[s];
            for (int l = 0; l < `ISSUE_WKUP_COUNT; l++) begin
                if (wkup_hit_i[s][l]) begin
                    patched[s] = wake_bus.wkup_data[l];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            real_data_o <= '0;
        end else if (advance_i) begin
            real_data_o <= patched;
        end
    end

endmodule

/* src/wake_bus_if.sv */
`timescale 1ns/1ps
`include "alu_issue_defs.svh"

interface wake_bus_if
    import core_types_pkg::*;
();

    // completion bus, tag and data in the same cycle
    word_t   [`ISSUE_CDB_COUNT-1:0]  cdb_data;
    rob_id_t [`ISSUE_CDB_COUNT-1:0]  cdb_tag;
    logic    [`ISSUE_CDB_COUNT-1:0]  cdb_valid;

    // early wakeup, data follows tag by one cycle
    word_t   [`ISSUE_WKUP_COUNT-1:0] wkup_data;
    rob_id_t [`ISSUE_WKUP_COUNT-1:0] wkup_tag;
    logic    [`ISSUE_WKUP_COUNT-1:0] wkup_valid;

    modport producer (
        output cdb_data, cdb_tag, cdb_valid,
        output wkup_data, wkup_tag, wkup_valid
    );

    modport consumer (
        input cdb_data, cdb_tag, cdb_valid,
        input wkup_data, wkup_tag, wkup_valid
    );

endinterface

/* verification/alu_issue_tb.sv */
`timescale 1ns/1ps
`include "alu_issue_defs.svh"

module alu_issue_tb
    import core_types_pkg::*;
    import alu_issue_pkg::*;
();

    localparam int TIMEOUT = 300;
    localparam int N_TAGS  = 1 << `ISSUE_ROB_ID_WIDTH;

    logic clk;
    logic rst_i;
    logic flush_i;
    logic [`ISSUE_DISPATCH_CNT-1:0]                              dispatch_choose_i;
    decode_info_t [`ISSUE_DISPATCH_CNT-1:0]                      dispatch_info_i;
    word_t [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0]       dispatch_data_i;
    rob_id_t [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0]     dispatch_tag_i;
    logic [`ISSUE_DISPATCH_CNT-1:0][`ISSUE_REG_COUNT-1:0]        dispatch_valid_i;
    word_t   [`ISSUE_CDB_COUNT-1:0] cdb_data_i;
    rob_id_t [`ISSUE_CDB_COUNT-1:0] cdb_tag_i;
    logic    [`ISSUE_CDB_COUNT-1:0] cdb_valid_i;
    word_t   ext_wkup_data_i;
    rob_id_t ext_wkup_tag_i;
    logic    ext_wkup_valid_i;
    logic    result_ready_i;
    logic    entry_ready_o;
    logic    result_valid_o;
    word_t   result_data_o;
    rob_id_t result_tag_o;
    logic    result_wreg_o;
    logic    wkup_valid_o;
    rob_id_t wkup_tag_o;
    word_t   wkup_data_o;

    // scoreboard indexed by destination tag
    word_t   exp_data    [N_TAGS];
    logic    exp_pending [N_TAGS];
    int      wk_cycle    [N_TAGS];
    int      outstanding;
    int      disp_cnt;
    int      acc_cnt;
    int      err_cnt;
    int      check_cnt;
    int      cycle;
    int      next_tag;
    integer  seed;
    integer  ready_seed;
    logic    check_lat;
    logic    bp_mode;
    logic    last_wk_valid;
    rob_id_t last_wk_tag;
    rob_id_t tags [4];
    rob_id_t t;
    rob_id_t prod_tag;

    alu_issue_top alu_issue_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // random back-pressure
    always @(posedge clk) begin
        #2;
        if (bp_mode) begin
            result_ready_i = $random(ready_seed);
        end
    end

    // --------------------
    // reference model
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b,
                                      input word_t pc);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (op)
            ALU_ADD:   r = a + b;
            ALU_SUB:   r = a - b;
            ALU_AND:   r = a & b;
            ALU_OR:    r = a | b;
            ALU_XOR:   r = a ^ b;
            // flipping the sign bits turns a signed compare into an unsigned one
            ALU_SLT:   r = ({~a[$bits(word_t)-1], a[$bits(word_t)-2:0]} <
                            {~b[$bits(word_t)-1], b[$bits(word_t)-2:0]}) ? word_t'(1) : '0;
            ALU_SLTU:  r = (a < b) ? word_t'(1) : '0;
            ALU_SLL:   r = a << sh;
            ALU_SRL:   r = a >> sh;
            // logical shift with the vacated top bits filled by the sign
            ALU_SRA:   r = (a >> sh) | ({$bits(word_t){a[$bits(word_t)-1]}} & ~(~word_t'(0) >> sh));
            ALU_PCADD: r = pc + b;
            default:   r = '0;
        endcase
        return r;
    endfunction

    // --------------------
    // outputs sampled mid-cycle by the compare process
    always @(negedge clk) begin
        if (!rst_i) begin
            if (last_wk_valid) begin
                check_cnt++;
                assert (wkup_data_o == exp_data[last_wk_tag]) else begin
                    err_cnt++;
                    $display("ERR @%0t: wakeup data tag %0d got %h exp %h", $time,
                             last_wk_tag, wkup_data_o, exp_data[last_wk_tag]);
                end
            end
            last_wk_valid = wkup_valid_o;
            last_wk_tag   = wkup_tag_o;
            if (wkup_valid_o) begin
                wk_cycle[wkup_tag_o] = cycle;
            end
            if (result_valid_o && result_ready_i) begin
                acc_cnt++;
                check_cnt++;
                assert (exp_pending[result_tag_o]) else begin
                    err_cnt++;
                    $display("ERR @%0t: unexpected or repeated result tag %0d", $time,
                             result_tag_o);
                end
                if (exp_pending[result_tag_o]) begin
                    assert (result_data_o == exp_data[result_tag_o] && result_wreg_o) else begin
                        err_cnt++;
                        $display("ERR @%0t: result tag %0d got %h exp %h", $time,
                                 result_tag_o, result_data_o, exp_data[result_tag_o]);
                    end
                    if (check_lat) begin
                        assert (cycle == wk_cycle[result_tag_o] + 2) else begin
                            err_cnt++;
                            $display("ERR @%0t: tag %0d latency %0d cycles", $time,
                                     result_tag_o, cycle - wk_cycle[result_tag_o]);
                        end
                    end
                    exp_pending[result_tag_o] = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    // --------------------
    task automatic fail_timeout(input string what);
        err_cnt++;
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("checks=%0d errors=%0d", check_cnt, err_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    // values a and b feed the reference even when the operand arrives later
    task automatic dispatch_inst(input int lane, input alu_op_e op, input word_t a,
                                 input word_t b, input word_t pc, input logic [1:0] vld,
                                 input rob_id_t t0, input rob_id_t t1, output rob_id_t dst);
        int           waited;
        decode_info_t di;
        waited = 0;
        while (!entry_ready_o) begin
            next_edge();
            waited++;
            if (waited > TIMEOUT) fail_timeout("a free queue slot");
        end
        dst = rob_id_t'(next_tag);
        next_tag = (next_tag + 1) % 32;
        di.inst_valid = 1'b1;
        di.pc         = pc;
        di.op         = op;
        di.wreg       = 1'b1;
        di.wreg_id    = dst;
        dispatch_info_i[lane]     = di;
        dispatch_data_i[lane][0]  = vld[0] ? a : word_t'($random(seed));
        dispatch_data_i[lane][1]  = vld[1] ? b : word_t'($random(seed));
        dispatch_tag_i[lane]      = {t1, t0};
        dispatch_valid_i[lane]    = vld;
        dispatch_choose_i         = 1 << lane;
        exp_data[dst]    = alu_ref(op, a, b, pc);
        exp_pending[dst] = 1'b1;
        outstanding++;
        disp_cnt++;
        next_edge();
        dispatch_choose_i = '0;
    endtask

    task automatic random_inst(input int lane);
        alu_op_e op;
        word_t   pc;
        rob_id_t dst;
        op = alu_op_e'(4'($unsigned($random(seed)) % 11));
        pc = word_t'($random(seed)) & ~word_t'(3);
        dispatch_inst(lane, op, $random(seed), $random(seed), pc, 2'b11, '0, '0, dst);
    endtask

    task automatic cdb_broadcast(input logic [1:0] v, input rob_id_t t0, input rob_id_t t1,
                                 input word_t d0, input word_t d1);
        cdb_valid_i = v;
        cdb_tag_i   = {t1, t0};
        cdb_data_i  = {d1, d0};
        next_edge();
        cdb_valid_i = '0;
    endtask

    // tag first, data one cycle later
    task automatic ext_wakeup(input rob_id_t tag, input word_t data);
        ext_wkup_valid_i = 1'b1;
        ext_wkup_tag_i   = tag;
        next_edge();
        ext_wkup_valid_i = 1'b0;
        ext_wkup_data_i  = data;
        next_edge();
        ext_wkup_data_i  = $random(seed);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (outstanding > 0) begin
            next_edge();
            waited++;
            if (waited > TIMEOUT) fail_timeout("all pending results");
        end
    endtask

    // --------------------
    // stimulus
    initial begin
        int waited;
        seed = 32'hb106;
        ready_seed = 32'hb106 ^ 32'h5a5a;
        rst_i = 1'b1;
        flush_i = 1'b0;
        dispatch_choose_i = '0;
        dispatch_info_i = '0;
        dispatch_data_i = '0;
        dispatch_tag_i = '0;
        dispatch_valid_i = '0;
        cdb_data_i = '0;
        cdb_tag_i = '0;
        cdb_valid_i = '0;
        ext_wkup_data_i = '0;
        ext_wkup_tag_i = '0;
        ext_wkup_valid_i = 1'b0;
        result_ready_i = 1'b1;
        outstanding = 0;
        disp_cnt = 0;
        acc_cnt = 0;
        err_cnt = 0;
        check_cnt = 0;
        cycle = 0;
        next_tag = 0;
        check_lat = 1'b0;
        bp_mode = 1'b0;
        last_wk_valid = 1'b0;
        last_wk_tag = '0;
        for (int i = 0; i < N_TAGS; i++) begin
            exp_pending[i] = 1'b0;
            exp_data[i] = '0;
            wk_cycle[i] = 0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst_i = 1'b0;
        next_edge();

        // reset state
        check_cnt++;
        assert (!result_valid_o && !wkup_valid_o && entry_ready_o) else begin
            err_cnt++;
            $display("ERR @%0t: outputs wrong after reset", $time);
        end

        // ready operands, fixed latency
        check_lat = 1'b1;
        for (int i = 0; i < 40; i++) random_inst(i % 2);
        wait_drain();
        check_lat = 1'b0;

        // cdb wakeup of both sources
        dispatch_inst(0, ALU_SUB, 32'h1234_5678, 32'h0000_1111, 32'h100, 2'b00, 6'd32,
                      6'd33, t);
        repeat (6) next_edge();
        check_cnt++;
        assert (exp_pending[t]) else begin
            err_cnt++;
            $display("ERR @%0t: tag %0d completed before its operands", $time, t);
        end
        cdb_broadcast(2'b01, 6'd32, 6'd0, 32'h1234_5678, 32'h0);
        cdb_broadcast(2'b10, 6'd0, 6'd33, 32'h0, 32'h0000_1111);
        wait_drain();

        // early wakeup through the internal loop-back then the external lane
        prod_tag = rob_id_t'((next_tag + 1) % 32);
        dispatch_inst(1, ALU_SLL, alu_ref(ALU_ADD, 32'd100, 32'd23, 32'h0), 32'd4, 32'h200,
                      2'b10, prod_tag, 6'd0, t);
        dispatch_inst(0, ALU_ADD, 32'd100, 32'd23, 32'h204, 2'b11, 6'd0, 6'd0, t);
        dispatch_inst(0, ALU_XOR, 32'hff00_ff00, 32'h0f0f_0f0f, 32'h208, 2'b01, 6'd0,
                      6'd40, t);
        repeat (2) next_edge();
        ext_wakeup(6'd40, 32'h0f0f_0f0f);
        wait_drain();

        // full queue released by the cdb
        for (int k = 0; k < 4; k++) begin
            dispatch_inst(k % 2, ALU_OR, 32'hc0de_0000 + k, 32'h10 * k, 32'h300, 2'b10,
                          rob_id_t'(48 + k), 6'd0, tags[k]);
        end
        repeat (3) next_edge();
        check_cnt++;
        assert (!entry_ready_o && outstanding == 4) else begin
            err_cnt++;
            $display("ERR @%0t: queue not full with four waiting entries", $time);
        end
        cdb_broadcast(2'b11, 6'd48, 6'd49, 32'hc0de_0000, 32'hc0de_0001);
        cdb_broadcast(2'b11, 6'd50, 6'd51, 32'hc0de_0002, 32'hc0de_0003);
        waited = 0;
        while (!entry_ready_o) begin
            next_edge();
            waited++;
            if (waited > TIMEOUT) fail_timeout("entry_ready_o after release");
        end
        wait_drain();

        // flush with four entries pending
        for (int k = 0; k < 4; k++) begin
            dispatch_inst(k % 2, ALU_ADD, 32'h5, 32'h6, 32'h400, 2'b10, rob_id_t'(52 + k),
                          6'd0, tags[k]);
        end
        flush_i = 1'b1;
        for (int k = 0; k < 4; k++) exp_pending[tags[k]] = 1'b0;
        outstanding -= 4;
        disp_cnt -= 4;
        next_edge();
        flush_i = 1'b0;
        check_cnt++;
        assert (entry_ready_o) else begin
            err_cnt++;
            $display("ERR @%0t: entry_ready_o low after flush", $time);
        end
        cdb_broadcast(2'b11, 6'd52, 6'd53, 32'h1, 32'h2);
        cdb_broadcast(2'b11, 6'd54, 6'd55, 32'h3, 32'h4);
        for (int k = 0; k < 8; k++) begin
            check_cnt++;
            assert (!result_valid_o) else begin
                err_cnt++;
                $display("ERR @%0t: result after flush", $time);
            end
            next_edge();
        end

        // long random run under back-pressure
        bp_mode = 1'b1;
        for (int i = 0; i < 200; i++) begin
            if (($random(seed) & 3) != 0) begin
                random_inst($unsigned($random(seed)) % 2);
            end else begin
                next_edge();
            end
        end
        bp_mode = 1'b0;
        result_ready_i = 1'b1;
        wait_drain();

        check_cnt++;
        assert (acc_cnt == disp_cnt) else begin
            err_cnt++;
            $display("ERR @%0t: accepted %0d results for %0d dispatched", $time,
                     acc_cnt, disp_cnt);
        end
        $display("checks=%0d errors=%0d dispatched=%0d accepted=%0d", check_cnt, err_cnt,
                 disp_cnt, acc_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
